// ==== Bender.yml ====
package:
  name: rv32i_single_cycle_core

dependencies: {}

sources:
  - rtl/rvIsaPkg.sv
  - rtl/dataMemPkg.sv
  - rtl/instDecoder.sv
  - rtl/regFile.sv
  - rtl/csrFile.sv
  - rtl/execStage.sv
  - rtl/coreTop.sv
  - target: simulation
    files:
      - testbench/coreAssertions.sv
      - testbench/coreTb.sv

// ==== project.f ====
rtl/rvIsaPkg.sv
rtl/dataMemPkg.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/csrFile.sv
rtl/execStage.sv
rtl/coreTop.sv
testbench/coreAssertions.sv
testbench/coreTb.sv

// ==== testbench/coreTb.sv ====
// Testbench for coreTop. Instructions come from a per-cycle table, so a pc
// visited twice may carry different instructions. Data memory is 16 words.
`timescale 1ns/1ns
`default_nettype none

module coreTb;

  localparam int clkPeriod = 100;
  localparam int maxRows = 32;
  localparam rvIsaPkg::wordT resetVec = 32'h0000_0100;
  localparam dataMemPkg::byteMaskT fullMask = 4'b1111;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opSys = 7'b1110011;

  logic                 clk;
  logic                 rst;
  logic                 instValid;
  rvIsaPkg::wordT       inst;
  rvIsaPkg::wordT       instAddr;
  rvIsaPkg::wordT       dataAddr;
  rvIsaPkg::wordT       dataWdata;
  rvIsaPkg::wordT       dataRdata;
  dataMemPkg::byteMaskT dataWmask;
  logic                 dataWe;
  logic                 dataRe;
  logic                 halt;

  rvIsaPkg::wordT dataMem [16];

  // one row per cycle: stimulus and the expected outputs
  string          nameTab  [maxRows];
  logic           validTab [maxRows];
  rvIsaPkg::wordT instTab  [maxRows];
  rvIsaPkg::wordT pcTab    [maxRows];
  logic           weTab    [maxRows];
  logic           reTab    [maxRows];
  rvIsaPkg::wordT addrTab  [maxRows];
  rvIsaPkg::wordT wdataTab [maxRows];
  logic           haltTab  [maxRows];
  int nRows = 0;
  int errors = 0;
  int cycleCount = 0;

  coreTop #(.resetVector(resetVec), .regAddrWidth(5)) u_dut (
    .clk, .rst, .instValid, .inst, .instAddr, .dataAddr, .dataWdata,
    .dataWmask, .dataWe, .dataRe, .dataRdata, .halt
  );

  bind coreTop coreAssertions u_assertions (.clk, .rst, .instValid, .dataWe, .dataRe, .pc);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // preset pattern, every word differs
  function automatic rvIsaPkg::wordT fillWord(input int idx);
    logic [3:0] n;
    n = idx[3:0];
    return 32'hF0E1_D2C3 ^ {8{n}};
  endfunction

  assign dataRdata = dataMem[dataAddr[5:2]];

  always @(posedge clk) begin
    if (dataWe) begin
      for (int b = 0; b < 4; b++) begin
        if (dataWmask[b]) begin
          dataMem[dataAddr[5:2]][8*b +: 8] <= dataWdata[8*b +: 8];
        end
      end
    end
  end

  // instruction encoders
  function automatic rvIsaPkg::wordT encR(input logic [6:0] f7, input int rs2,
                                          input int rs1, input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic rvIsaPkg::wordT encI(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] op);
    return {imm, rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic rvIsaPkg::wordT encS(input logic [11:0] imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rvIsaPkg::wordT encB(input logic [12:0] imm, input int rs2,
                                          input int rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rvIsaPkg::wordT encJ(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic rvIsaPkg::wordT encU(input logic [19:0] imm, input int rd);
    return {imm, rd[4:0], 7'b0110111};
  endfunction

  task automatic checkWord(input string what, input rvIsaPkg::wordT expected,
                           input rvIsaPkg::wordT actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  task automatic checkBit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", what, expected, actual);
    end
  endtask

  task automatic checkMask(input string what, input dataMemPkg::byteMaskT expected,
                           input dataMemPkg::byteMaskT actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", what, expected, actual);
    end
  endtask

  task automatic addRow(input string name, input logic valid, input rvIsaPkg::wordT ins,
                        input rvIsaPkg::wordT pc, input logic we, input logic re,
                        input rvIsaPkg::wordT addr, input rvIsaPkg::wordT wdata,
                        input logic hlt);
    nameTab[nRows] = name;
    validTab[nRows] = valid;
    instTab[nRows] = ins;
    pcTab[nRows] = pc;
    weTab[nRows] = we;
    reTab[nRows] = re;
    addrTab[nRows] = addr;
    wdataTab[nRows] = wdata;
    haltTab[nRows] = hlt;
    nRows++;
  endtask

  task automatic buildTable();
    rvIsaPkg::wordT w3;
    rvIsaPkg::wordT lbExp;
    w3 = fillWord(3);
    lbExp = {{24{w3[15]}}, w3[15:8]};
    addRow("stall", 0, encS(12'd32, 0, 0), resetVec, 0, 0, 0, 0, 0);
    // x1 = 12345000, x2 = -3, x3 = x1 - x2 = 12345003
    addRow("lui", 1, encU(20'h12345, 1), 32'h100, 0, 0, 0, 0, 0);
    addRow("addi", 1, encI(12'hFFD, 0, 3'b000, 2, opImm), 32'h104, 0, 0, 0, 0, 0);
    addRow("sub", 1, encR(7'b0100000, 2, 1, 3'b000, 3), 32'h108, 0, 0, 0, 0, 0);
    // signed -3 < x1 gives 1, unsigned gives 0
    addRow("slt", 1, encR(7'b0, 1, 2, 3'b010, 4), 32'h10C, 0, 0, 0, 0, 0);
    addRow("sltu", 1, encR(7'b0, 1, 2, 3'b011, 5), 32'h110, 0, 0, 0, 0, 0);
    // x6 = (x3 + x5) ^ x4 = 12345002
    addRow("add", 1, encR(7'b0, 5, 3, 3'b000, 6), 32'h114, 0, 0, 0, 0, 0);
    addRow("xor", 1, encR(7'b0, 4, 6, 3'b100, 6), 32'h118, 0, 0, 0, 0, 0);
    // word 3 and its byte lanes
    addRow("lw", 1, encI(12'd12, 0, 3'b010, 8, opLoad), 32'h11C, 0, 1, 32'd12, 0, 0);
    addRow("lb", 1, encI(12'd13, 0, 3'b000, 9, opLoad), 32'h120, 0, 1, 32'd13, 0, 0);
    addRow("lbu", 1, encI(12'd12, 0, 3'b100, 10, opLoad), 32'h124, 0, 1, 32'd12, 0, 0);
    addRow("sw lb at lbu", 1, encS(12'd0, 9, 10), 32'h128, 1, 0, {24'b0, w3[7:0]}, lbExp, 0);
    addRow("beq taken", 1, encB(13'd12, 1, 1, 3'b000), 32'h12C, 0, 0, 0, 0, 0);
    addRow("bne not taken", 1, encB(13'd12, 1, 1, 3'b001), 32'h138, 0, 0, 0, 0, 0);
    addRow("blt taken", 1, encB(13'd8, 1, 2, 3'b100), 32'h13C, 0, 0, 0, 0, 0);
    addRow("bltu not taken", 1, encB(13'd8, 1, 2, 3'b110), 32'h144, 0, 0, 0, 0, 0);
    addRow("jal", 1, encJ(21'd16, 13), 32'h148, 0, 0, 0, 0, 0);
    // address shows the link, data shows the alu chain
    addRow("sw at link", 1, encS(12'd0, 6, 13), 32'h158, 1, 0, 32'h14C, 32'h1234_5002, 0);
    addRow("csrrw mtvec", 1, encI(12'h305, 8, 3'b001, 0, opSys), 32'h15C, 0, 0, 0, 0, 0);
    addRow("ecall", 1, 32'h0000_0073, 32'h160, 0, 0, 0, 0, 0);
    addRow("mret", 1, 32'h3020_0073, w3, 0, 0, 0, 0, 0);
    addRow("csrrw mepc", 1, encI(12'h341, 0, 3'b001, 12, opSys), 32'h160, 0, 0, 0, 0, 0);
    addRow("addi x0", 1, encI(12'd5, 0, 3'b000, 0, opImm), 32'h164, 0, 0, 0, 0, 0);
    addRow("sw x0 at mepc", 1, encS(12'd0, 0, 12), 32'h168, 1, 0, 32'h160, 32'h0, 0);
    // logic ops build x7 = 12345001, stored to word 2
    addRow("ori", 1, encI(12'h00F, 3, 3'b110, 7, opImm), 32'h16C, 0, 0, 0, 0, 0);
    addRow("or", 1, encR(7'b0, 13, 7, 3'b110, 7), 32'h170, 0, 0, 0, 0, 0);
    addRow("andi", 1, encI(12'hFF9, 7, 3'b111, 7, opImm), 32'h174, 0, 0, 0, 0, 0);
    addRow("and", 1, encR(7'b0, 3, 7, 3'b111, 7), 32'h178, 0, 0, 0, 0, 0);
    addRow("sw logic", 1, encS(12'd8, 7, 0), 32'h17C, 1, 0, 32'd8, 32'h1234_5001, 0);
    addRow("ebreak", 1, 32'h0010_0073, 32'h180, 0, 0, 0, 0, 1);
  endtask

  initial begin
    rst = 1'b1;
    instValid = 1'b0;
    inst = 32'h0000_0013;
    for (int i = 0; i < 16; i++) begin
      dataMem[i] = fillWord(i);
    end
    buildTable();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    checkWord("reset instAddr", resetVec, instAddr);
    checkBit("reset dataWe", 1'b0, dataWe);
    checkBit("reset dataRe", 1'b0, dataRe);
    for (int i = 0; i < nRows; i++) begin
      instValid = validTab[i];
      inst = instTab[i];
      // sample just before the rising edge
      #(clkPeriod / 2 - 10);
      checkWord({nameTab[i], " instAddr"}, pcTab[i], instAddr);
      checkBit({nameTab[i], " dataWe"}, weTab[i], dataWe);
      checkBit({nameTab[i], " dataRe"}, reTab[i], dataRe);
      if (weTab[i] || reTab[i]) begin
        checkWord({nameTab[i], " dataAddr"}, addrTab[i], dataAddr);
      end
      if (weTab[i]) begin
        checkWord({nameTab[i], " dataWdata"}, wdataTab[i], dataWdata);
        checkMask({nameTab[i], " dataWmask"}, fullMask, dataWmask);
      end
      checkBit({nameTab[i], " halt"}, haltTab[i], halt);
      @(negedge clk);
    end
    errors += u_dut.u_assertions.failCount;
    $display("Rows: %0d, errors: %0d", nRows, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog, limit follows the table length
  initial begin
    while (cycleCount <= nRows + 10) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycleCount);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/coreAssertions.sv ====
// Concurrent checks on the memory strobes and the pc of coreTop.
// Bound into coreTop by the testbench.
`timescale 1ns/1ns
`default_nettype none

module coreAssertions (
  input logic           clk,
  input logic           rst,
  input logic           instValid,
  input logic           dataWe,
  input logic           dataRe,
  input rvIsaPkg::wordT pc
);

  // number of failed assertions so far
  int failCount = 0;

  // one instruction either loads or stores, never both
  strobeExclusive: assert property (@(posedge clk) disable iff (rst) !(dataWe && dataRe))
    else begin
      failCount++;
      $error("data read and write strobes high in the same cycle");
    end

  strobeGated: assert property (@(posedge clk) disable iff (rst)
    !instValid |-> (!dataWe && !dataRe))
    else begin
      failCount++;
      $error("memory strobe high while instValid is low");
    end

  // a stalled cycle must not move the pc
  pcHeld: assert property (@(posedge clk) disable iff (rst) !instValid |=> $stable(pc))
    else begin
      failCount++;
      $error("pc changed after a cycle with instValid low");
    end

endmodule

`default_nettype wire

// ==== rtl/coreTop.sv ====
// Single-cycle RV32I subset core. Instruction and data memories are
// external and must answer combinationally within the cycle.
`timescale 1ns/1ns
`default_nettype none

module coreTop #(
  parameter rvIsaPkg::wordT resetVector  = '0,
  parameter int             regAddrWidth = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instValid,
  input  rvIsaPkg::wordT       inst,
  output rvIsaPkg::wordT       instAddr,
  output rvIsaPkg::wordT       dataAddr,
  output rvIsaPkg::wordT       dataWdata,
  output dataMemPkg::byteMaskT dataWmask,
  output logic                 dataWe,
  output logic                 dataRe,
  input  rvIsaPkg::wordT       dataRdata,
  output logic                 halt
);

  rvIsaPkg::wordT     pc, dnpc, imm, rdata1, rdata2, aluOut, wbData;
  rvIsaPkg::wordT     csrRdata, mtvec, mepc;
  rvIsaPkg::aluOpT    aluOp;
  rvIsaPkg::aluBSelT  aluBSel;
  rvIsaPkg::wbSelT    wbSel;
  dataMemPkg::memExtT memExt;
  logic aluASelPc, regWrite, memRead, memWrite, csrWrite;
  logic brUnsigned, takeTarget, brEq, brLt, ecall, mret, ebreak;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= resetVector;
    end else begin
      pc <= dnpc;
    end
  end

  assign instAddr  = pc;
  assign dataAddr  = aluOut;
  assign dataWdata = rdata2;
  assign dataWmask = memWrite ? dataMemPkg::maskWord : dataMemPkg::maskNone;
  // every side effect is qualified by instValid
  assign dataWe = memWrite & instValid;
  assign dataRe = memRead & instValid;
  assign halt   = ebreak & instValid;

  instDecoder u_decoder (
    .inst, .brEq, .brLt, .aluOp, .aluASelPc, .aluBSel, .wbSel, .regWrite,
    .memRead, .memWrite, .memExt, .csrWrite, .brUnsigned, .takeTarget,
    .ecall, .mret, .ebreak, .imm
  );

  regFile #(.regAddrWidth(regAddrWidth)) u_regFile (
    .clk, .rst, .wen(regWrite & instValid), .waddr(inst[11:7]),
    .raddr1(inst[19:15]), .raddr2(inst[24:20]), .wdata(wbData), .rdata1, .rdata2
  );

  csrFile u_csrFile (
    .clk, .rst, .csrEn(csrWrite & instValid), .csrId(inst[31:20]), .wdata(aluOut),
    .ecall(ecall & instValid), .pc, .rdata(csrRdata), .mtvec, .mepc
  );

  execStage u_exec (
    .pc, .imm, .rdata1, .rdata2, .csrRdata, .mtvec, .mepc, .aluOp, .aluASelPc,
    .aluBSel, .wbSel, .memExt, .brUnsigned, .takeTarget, .ecall, .mret,
    .instValid, .dataRdata, .brEq, .brLt, .aluOut, .wbData, .dnpc
  );

endmodule

`default_nettype wire

// ==== rtl/execStage.sv ====
// Combinational execute and write-back path for one instruction.
// Byte loads pick the lane from the low address bits; no alignment checks.
`timescale 1ns/1ns
`default_nettype none

module execStage (
  input  rvIsaPkg::wordT     pc,
  input  rvIsaPkg::wordT     imm,
  input  rvIsaPkg::wordT     rdata1,
  input  rvIsaPkg::wordT     rdata2,
  input  rvIsaPkg::wordT     csrRdata,
  input  rvIsaPkg::wordT     mtvec,
  input  rvIsaPkg::wordT     mepc,
  input  rvIsaPkg::aluOpT    aluOp,
  input  logic               aluASelPc,
  input  rvIsaPkg::aluBSelT  aluBSel,
  input  rvIsaPkg::wbSelT    wbSel,
  input  dataMemPkg::memExtT memExt,
  input  logic               brUnsigned,
  input  logic               takeTarget,
  input  logic               ecall,
  input  logic               mret,
  input  logic               instValid,
  input  rvIsaPkg::wordT     dataRdata,
  output logic               brEq,
  output logic               brLt,
  output rvIsaPkg::wordT     aluOut,
  output rvIsaPkg::wordT     wbData,
  output rvIsaPkg::wordT     dnpc
);

  rvIsaPkg::wordT aluA;
  rvIsaPkg::wordT aluB;
  rvIsaPkg::wordT pcPlus4;
  rvIsaPkg::wordT loadData;
  logic [7:0]     loadByte;

  assign pcPlus4 = pc + 32'd4;
  assign aluA    = aluASelPc ? pc : rdata1;

  always_comb begin
    case (aluBSel)
      rvIsaPkg::aluBReg: aluB = rdata2;
      rvIsaPkg::aluBCsr: aluB = csrRdata;
      default:           aluB = imm;
    endcase
  end

  always_comb begin
    case (aluOp)
      rvIsaPkg::aluSub:   aluOut = aluA - aluB;
      rvIsaPkg::aluAnd:   aluOut = aluA & aluB;
      rvIsaPkg::aluOr:    aluOut = aluA | aluB;
      rvIsaPkg::aluXor:   aluOut = aluA ^ aluB;
      rvIsaPkg::aluSlt:   aluOut = {31'b0, $signed(aluA) < $signed(aluB)};
      rvIsaPkg::aluSltu:  aluOut = {31'b0, aluA < aluB};
      rvIsaPkg::aluPassB: aluOut = aluB;
      default:            aluOut = aluA + aluB;
    endcase
  end

  // branch compare always works on the register operands
  assign brEq = (rdata1 == rdata2);
  assign brLt = brUnsigned ? (rdata1 < rdata2) : ($signed(rdata1) < $signed(rdata2));

  assign loadByte = dataRdata[{aluOut[1:0], 3'b000} +: 8];

  always_comb begin
    case (memExt)
      dataMemPkg::extByteSigned:   loadData = {{24{loadByte[7]}}, loadByte};
      dataMemPkg::extByteUnsigned: loadData = {24'b0, loadByte};
      default:                     loadData = dataRdata;
    endcase
  end

  always_comb begin
    case (wbSel)
      rvIsaPkg::wbMem: wbData = loadData;
      rvIsaPkg::wbPc4: wbData = pcPlus4;
      rvIsaPkg::wbCsr: wbData = csrRdata;
      default:         wbData = aluOut;
    endcase
  end

  // next pc, highest priority first
  always_comb begin
    if (!instValid) begin
      dnpc = pc;
    end else if (mret) begin
      dnpc = mepc;
    end else if (ecall) begin
      dnpc = mtvec;
    end else if (takeTarget) begin
      dnpc = aluOut;
    end else begin
      dnpc = pcPlus4;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/csrFile.sv ====
// Machine CSRs mtvec and mepc only. Other CSR numbers read zero and
// ignore writes. Enables are expected already qualified by instValid.
`timescale 1ns/1ns
`default_nettype none

module csrFile (
  input  logic              clk,
  input  logic              rst,
  input  logic              csrEn,
  input  rvIsaPkg::csrAddrT csrId,
  input  rvIsaPkg::wordT    wdata,
  input  logic              ecall,
  input  rvIsaPkg::wordT    pc,
  output rvIsaPkg::wordT    rdata,
  output rvIsaPkg::wordT    mtvec,
  output rvIsaPkg::wordT    mepc
);

  rvIsaPkg::wordT mtvecQ;
  rvIsaPkg::wordT mepcQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvecQ <= '0;
      mepcQ  <= '0;
    end else if (ecall) begin
      // trap entry saves the pc of the ecall itself
      mepcQ <= pc;
    end else if (csrEn) begin
      case (csrId)
        rvIsaPkg::csrMtvec: mtvecQ <= wdata;
        rvIsaPkg::csrMepc:  mepcQ  <= wdata;
        default: ;
      endcase
    end
  end

  // old value for the csrrw read
  always_comb begin
    case (csrId)
      rvIsaPkg::csrMtvec: rdata = mtvecQ;
      rvIsaPkg::csrMepc:  rdata = mepcQ;
      default:            rdata = '0;
    endcase
  end

  assign mtvec = mtvecQ;
  assign mepc  = mepcQ;

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
// General-purpose registers, two async reads and one sync write.
// With regAddrWidth 4 the upper index bit is ignored.
`timescale 1ns/1ns
`default_nettype none

module regFile #(
  parameter int regAddrWidth = 5
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wen,
  input  rvIsaPkg::regAddrT waddr,
  input  rvIsaPkg::regAddrT raddr1,
  input  rvIsaPkg::regAddrT raddr2,
  input  rvIsaPkg::wordT    wdata,
  output rvIsaPkg::wordT    rdata1,
  output rvIsaPkg::wordT    rdata2
);

  rvIsaPkg::wordT regs [2**regAddrWidth];

  // x0 is cleared at reset and never written, so it reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr[regAddrWidth-1:0] != '0) begin
      regs[waddr[regAddrWidth-1:0]] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1[regAddrWidth-1:0]];
  assign rdata2 = regs[raddr2[regAddrWidth-1:0]];

endmodule

`default_nettype wire

// ==== rtl/instDecoder.sv ====
// Combinational decoder for the RV32I subset. Unsupported encodings decode
// as a no-op with no writes and fall through to pc + 4.
`timescale 1ns/1ns
`default_nettype none

module instDecoder (
  input  rvIsaPkg::wordT     inst,
  input  logic               brEq,
  input  logic               brLt,
  output rvIsaPkg::aluOpT    aluOp,
  output logic               aluASelPc,
  output rvIsaPkg::aluBSelT  aluBSel,
  output rvIsaPkg::wbSelT    wbSel,
  output logic               regWrite,
  output logic               memRead,
  output logic               memWrite,
  output dataMemPkg::memExtT memExt,
  output logic               csrWrite,
  output logic               brUnsigned,
  output logic               takeTarget,
  output logic               ecall,
  output logic               mret,
  output logic               ebreak,
  output rvIsaPkg::wordT     imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // bltu has funct3[1] set, blt and the equality tests do not
  assign brUnsigned = funct3[1];

  always_comb begin
    aluOp      = rvIsaPkg::aluAdd;
    aluASelPc  = 1'b0;
    aluBSel    = rvIsaPkg::aluBImm;
    wbSel      = rvIsaPkg::wbAlu;
    regWrite   = 1'b0;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    memExt     = dataMemPkg::extWord;
    csrWrite   = 1'b0;
    takeTarget = 1'b0;
    ecall      = 1'b0;
    mret       = 1'b0;
    ebreak     = 1'b0;
    case (opcode)
      rvIsaPkg::opLui: begin
        aluOp    = rvIsaPkg::aluPassB;
        regWrite = 1'b1;
      end
      rvIsaPkg::opAuipc: begin
        aluASelPc = 1'b1;
        regWrite  = 1'b1;
      end
      rvIsaPkg::opJal: begin
        aluASelPc  = 1'b1;
        wbSel      = rvIsaPkg::wbPc4;
        regWrite   = 1'b1;
        takeTarget = 1'b1;
      end
      rvIsaPkg::opBranch: begin
        // alu forms pc + imm; funct3[0] inverts the test (bne)
        aluASelPc  = 1'b1;
        takeTarget = funct3[2] ? (brLt ^ funct3[0]) : (brEq ^ funct3[0]);
      end
      rvIsaPkg::opLoad: begin
        memRead  = 1'b1;
        regWrite = 1'b1;
        wbSel    = rvIsaPkg::wbMem;
        if (funct3 == rvIsaPkg::f3Byte) begin
          memExt = dataMemPkg::extByteSigned;
        end else if (funct3 == rvIsaPkg::f3ByteU) begin
          memExt = dataMemPkg::extByteUnsigned;
        end
      end
      rvIsaPkg::opStore: begin
        memWrite = 1'b1;
      end
      rvIsaPkg::opOpImm, rvIsaPkg::opOp: begin
        regWrite = 1'b1;
        if (opcode == rvIsaPkg::opOp) begin
          aluBSel = rvIsaPkg::aluBReg;
        end
        case (funct3)
          rvIsaPkg::f3AddSub: begin
            if (opcode == rvIsaPkg::opOp && inst[30]) begin
              aluOp = rvIsaPkg::aluSub;
            end
          end
          rvIsaPkg::f3Slt:  aluOp = rvIsaPkg::aluSlt;
          rvIsaPkg::f3Sltu: aluOp = rvIsaPkg::aluSltu;
          rvIsaPkg::f3Xor:  aluOp = rvIsaPkg::aluXor;
          rvIsaPkg::f3Or:   aluOp = rvIsaPkg::aluOr;
          rvIsaPkg::f3And:  aluOp = rvIsaPkg::aluAnd;
          default: ;
        endcase
      end
      rvIsaPkg::opSystem: begin
        if (funct3 == rvIsaPkg::f3Csrrw) begin
          // rs1 + 0 reaches the CSR write port through the alu
          csrWrite = 1'b1;
          regWrite = 1'b1;
          wbSel    = rvIsaPkg::wbCsr;
        end else if (funct3 == 3'b000) begin
          ecall  = (inst[31:20] == rvIsaPkg::f12Ecall);
          ebreak = (inst[31:20] == rvIsaPkg::f12Ebreak);
          mret   = (inst[31:20] == rvIsaPkg::f12Mret);
        end
      end
      default: ;
    endcase
  end

  // immediate formats; system instructions get zero
  always_comb begin
    case (opcode)
      rvIsaPkg::opLui, rvIsaPkg::opAuipc: imm = {inst[31:12], 12'b0};
      rvIsaPkg::opJal:
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      rvIsaPkg::opBranch:
        imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      rvIsaPkg::opStore:  imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      rvIsaPkg::opLoad, rvIsaPkg::opOpImm: imm = {{21{inst[31]}}, inst[30:20]};
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dataMemPkg.sv ====
// Data-memory access codes. Only word and byte accesses exist.
`default_nettype none

package dataMemPkg;

  typedef logic [3:0] byteMaskT;

  localparam byteMaskT maskNone = 4'b0000;
  localparam byteMaskT maskWord = 4'b1111;

  // how a load result is extended before write-back
  typedef logic [1:0] memExtT;

  localparam memExtT extWord         = 2'd0;
  localparam memExtT extByteSigned   = 2'd1;
  localparam memExtT extByteUnsigned = 2'd2;

endpackage

`default_nettype wire

// ==== rtl/rvIsaPkg.sv ====
// RV32I subset encodings, control codes and the datapath word type.
// Only the opcodes and function codes that the core decodes are listed.
`default_nettype none

package rvIsaPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;
  typedef logic [11:0] csrAddrT;

  localparam csrAddrT csrMtvec = 12'h305;
  localparam csrAddrT csrMepc  = 12'h341;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opSystem = 7'b1110011;

  // funct3, inst[14:12]
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Byte   = 3'b000;
  localparam logic [2:0] f3ByteU  = 3'b100;
  localparam logic [2:0] f3Csrrw  = 3'b001;

  // funct12 of the system instructions with funct3 zero
  localparam logic [11:0] f12Ecall  = 12'h000;
  localparam logic [11:0] f12Ebreak = 12'h001;
  localparam logic [11:0] f12Mret   = 12'h302;

  typedef logic [3:0] aluOpT;
  localparam aluOpT aluAdd   = 4'd0;
  localparam aluOpT aluSub   = 4'd1;
  localparam aluOpT aluAnd   = 4'd2;
  localparam aluOpT aluOr    = 4'd3;
  localparam aluOpT aluXor   = 4'd4;
  localparam aluOpT aluSlt   = 4'd5;
  localparam aluOpT aluSltu  = 4'd6;
  localparam aluOpT aluPassB = 4'd7;

  typedef logic [1:0] aluBSelT;
  localparam aluBSelT aluBReg = 2'd0;
  localparam aluBSelT aluBImm = 2'd1;
  localparam aluBSelT aluBCsr = 2'd2;

  typedef logic [1:0] wbSelT;
  localparam wbSelT wbMem = 2'd0;
  localparam wbSelT wbAlu = 2'd1;
  localparam wbSelT wbPc4 = 2'd2;
  localparam wbSelT wbCsr = 2'd3;

endpackage

`default_nettype wire
